// ==== logic/accel_macros.svh ====
`ifndef ACCEL_MACROS_SVH
`define ACCEL_MACROS_SVH

// width of one memory sample
`define ACCEL_DATA_WIDTH 16

// sample memory address width
`define ACCEL_ADDR_WIDTH 12

// number of sample words, one full address space so reads wrap on their own
`define ACCEL_MEM_DEPTH 4096

// words returned per block read, one 5x5 window
`define ACCEL_BLOCK_SIZE 25

// signed result width, room for 25 full-scale products
`define ACCEL_ACC_WIDTH 40

// kernel tap index width, enough for taps 0 to 24
`define ACCEL_INDEX_WIDTH 5

// window count width for one run
`define ACCEL_COUNT_WIDTH 8

`endif

// ==== logic/accelPkg.sv ====
`include "accel_macros.svh"

package accelPkg;

    // one signed memory sample
    typedef logic signed [`ACCEL_DATA_WIDTH-1:0] sampleT;

    // signed dot-product result
    typedef logic signed [`ACCEL_ACC_WIDTH-1:0] accT;

    // whole block from one read
    // element 0 holds the word at the read address
    typedef sampleT [`ACCEL_BLOCK_SIZE-1:0] blockT;

    // sequencer states
    // idle takes host writes, run issues block reads
    typedef enum logic {
        idle = 1'b0,
        run  = 1'b1
    } seqStateT;

endpackage

// ==== logic/windowSequencer.sv ====
`include "accel_macros.svh"

module windowSequencer (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          hostWrite,
    input  logic [`ACCEL_ADDR_WIDTH-1:0]  hostAddr,
    input  accelPkg::sampleT              hostData,
    input  logic                          start,
    input  logic [`ACCEL_ADDR_WIDTH-1:0]  baseAddr,
    input  logic [`ACCEL_ADDR_WIDTH-1:0]  stride,
    input  logic [`ACCEL_COUNT_WIDTH-1:0] windowCount,
    output logic                          busy,
    output logic                          memEnable,
    output logic                          memRead,
    output logic [`ACCEL_ADDR_WIDTH-1:0]  memAddr,
    output accelPkg::sampleT              memWriteData
);

    // run control
    accelPkg::seqStateT state;
    logic [`ACCEL_COUNT_WIDTH-1:0] windowsLeft;

    // address of the window being read this cycle
    logic [`ACCEL_ADDR_WIDTH-1:0] windowAddr;
    // stride captured at start
    logic [`ACCEL_ADDR_WIDTH-1:0] strideReg;

    logic startAccepted;
    logic lastWindow;
    logic [`ACCEL_COUNT_WIDTH-1:0] runLength;

    // start only counts while idle
    assign startAccepted = start && (state == accelPkg::idle);

    // final read of the run goes out this cycle
    assign lastWindow = (windowsLeft == `ACCEL_COUNT_WIDTH'(1));

    // a zero count still gives one window
    assign runLength = (windowCount == '0) ? `ACCEL_COUNT_WIDTH'(1) : windowCount;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state       <= accelPkg::idle;
            windowsLeft <= '0;
        end else begin
            case (state)
                accelPkg::idle: begin
                    if (startAccepted) begin
                        state       <= accelPkg::run;
                        windowsLeft <= runLength;
                    end
                end
                accelPkg::run: begin
                    // one read per cycle, leave after the last one
                    windowsLeft <= windowsLeft - `ACCEL_COUNT_WIDTH'(1);
                    if (lastWindow) begin
                        state <= accelPkg::idle;
                    end
                end
                default: begin
                    state <= accelPkg::idle;
                end
            endcase
        end
    end

    // window address walk
    // first read at baseAddr, then one stride per cycle, wraps at 4096
    always_ff @(posedge clk) begin
        if (startAccepted) begin
            windowAddr <= baseAddr;
            strideReg  <= stride;
        end else if (state == accelPkg::run) begin
            windowAddr <= windowAddr + strideReg;
        end
    end

    assign busy = (state == accelPkg::run);

    // reads own the port while running
    assign memRead = busy;

    // host writes pass straight through when idle, dropped otherwise
    assign memEnable = busy || hostWrite;
    assign memAddr   = busy ? windowAddr : hostAddr;

    // write data only matters on a write cycle
    assign memWriteData = hostData;

endmodule

// ==== logic/blockMemory.sv ====
`include "accel_macros.svh"

module blockMemory (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         memEnable,
    input  logic                         memRead,
    input  logic [`ACCEL_ADDR_WIDTH-1:0] memAddr,
    input  accelPkg::sampleT             memWriteData,
    output accelPkg::blockT              blockData,
    output logic                         blockValid
);

    // sample storage, contents undefined until written
    accelPkg::sampleT mem [`ACCEL_MEM_DEPTH];

    // word addresses of the block, one per lane
    logic [`ACCEL_ADDR_WIDTH-1:0] laneAddr [`ACCEL_BLOCK_SIZE];

    logic doRead;
    logic doWrite;

    assign doRead  = memEnable && memRead;
    assign doWrite = memEnable && !memRead;

    // consecutive addresses from memAddr
    // 12-bit sum so the block wraps past the top word
    always_comb begin
        for (int i = 0; i < `ACCEL_BLOCK_SIZE; i++) begin
            laneAddr[i] = memAddr + `ACCEL_ADDR_WIDTH'(i);
        end
    end

    // single word write
    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[memAddr] <= memWriteData;
        end
    end

    // block read, registered
    // lane 0 is the word at memAddr
    always_ff @(posedge clk) begin
        if (doRead) begin
            for (int i = 0; i < `ACCEL_BLOCK_SIZE; i++) begin
                blockData[i] <= mem[laneAddr[i]];
            end
        end
    end

    // valid one cycle after the read
    always_ff @(posedge clk) begin
        if (!rstN) begin
            blockValid <= 1'b0;
        end else begin
            blockValid <= doRead;
        end
    end

endmodule

// ==== logic/dotProductUnit.sv ====
`include "accel_macros.svh"

module dotProductUnit (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          kernelWrite,
    input  logic [`ACCEL_INDEX_WIDTH-1:0] kernelIndex,
    input  accelPkg::sampleT              kernelData,
    input  accelPkg::blockT               blockData,
    input  logic                          blockValid,
    output logic                          resultValid,
    output accelPkg::accT                 result
);

    // adder tree shape, 25 products padded to 32 leaves
    localparam int TREE_LEVELS = 5;
    localparam int TREE_LEAVES = 1 << TREE_LEVELS;
    localparam int PROD_WIDTH  = 2 * `ACCEL_DATA_WIDTH;

    // kernel taps, loaded by index
    accelPkg::sampleT kernel [`ACCEL_BLOCK_SIZE];

    // stage one
    logic signed [PROD_WIDTH-1:0] products [`ACCEL_BLOCK_SIZE];
    logic prodValid;

    // adder tree nodes, level 0 holds the leaves
    accelPkg::accT treeNode [TREE_LEVELS+1][TREE_LEAVES];

    // tap load
    // out of range index is ignored
    always_ff @(posedge clk) begin
        if (kernelWrite && (kernelIndex < `ACCEL_INDEX_WIDTH'(`ACCEL_BLOCK_SIZE))) begin
            kernel[kernelIndex] <= kernelData;
        end
    end

    // stage one, all 25 signed multiplies in parallel
    always_ff @(posedge clk) begin
        if (blockValid) begin
            for (int i = 0; i < `ACCEL_BLOCK_SIZE; i++) begin
                products[i] <= $signed(blockData[i]) * kernel[i];
            end
        end
    end

    // leaves sign-extended to result width, spare leaves zero
    // then pairwise sums down to one node
    always_comb begin
        for (int j = 0; j < TREE_LEAVES; j++) begin
            if (j < `ACCEL_BLOCK_SIZE) begin
                treeNode[0][j] = products[j];
            end else begin
                treeNode[0][j] = '0;
            end
        end
        for (int l = 0; l < TREE_LEVELS; l++) begin
            for (int j = 0; j < TREE_LEAVES; j++) begin
                if (j < (TREE_LEAVES >> (l + 1))) begin
                    treeNode[l+1][j] = treeNode[l][2*j] + treeNode[l][2*j+1];
                end else begin
                    // unused upper half of the level
                    treeNode[l+1][j] = '0;
                end
            end
        end
    end

    // stage two, registered sum
    always_ff @(posedge clk) begin
        if (prodValid) begin
            result <= treeNode[TREE_LEVELS][0];
        end
    end

    // valid follows the data through both stages
    always_ff @(posedge clk) begin
        if (!rstN) begin
            prodValid   <= 1'b0;
            resultValid <= 1'b0;
        end else begin
            prodValid   <= blockValid;
            resultValid <= prodValid;
        end
    end

endmodule

// ==== logic/accelTop.sv ====
`include "accel_macros.svh"

module accelTop (
    input  logic                          clk,
    input  logic                          rstN,
    // host writes into sample memory
    input  logic                          hostWrite,
    input  logic [`ACCEL_ADDR_WIDTH-1:0]  hostAddr,
    input  accelPkg::sampleT              hostData,
    // kernel tap loads
    input  logic                          kernelWrite,
    input  logic [`ACCEL_INDEX_WIDTH-1:0] kernelIndex,
    input  accelPkg::sampleT              kernelData,
    // run request
    input  logic                          start,
    input  logic [`ACCEL_ADDR_WIDTH-1:0]  baseAddr,
    input  logic [`ACCEL_ADDR_WIDTH-1:0]  stride,
    input  logic [`ACCEL_COUNT_WIDTH-1:0] windowCount,
    // status and results
    output logic                          busy,
    output logic                          resultValid,
    output accelPkg::accT                 result
);

    // sequencer to memory
    logic                         memEnable;
    logic                         memRead;
    logic [`ACCEL_ADDR_WIDTH-1:0] memAddr;
    accelPkg::sampleT             memWriteData;

    // memory to dot-product unit
    accelPkg::blockT blockData;
    logic            blockValid;

    // producer, host writes and strided reads
    windowSequencer sequencer (
        .clk          (clk),
        .rstN         (rstN),
        .hostWrite    (hostWrite),
        .hostAddr     (hostAddr),
        .hostData     (hostData),
        .start        (start),
        .baseAddr     (baseAddr),
        .stride       (stride),
        .windowCount  (windowCount),
        .busy         (busy),
        .memEnable    (memEnable),
        .memRead      (memRead),
        .memAddr      (memAddr),
        .memWriteData (memWriteData)
    );

    // sample buffer
    blockMemory memory (
        .clk          (clk),
        .rstN         (rstN),
        .memEnable    (memEnable),
        .memRead      (memRead),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .blockData    (blockData),
        .blockValid   (blockValid)
    );

    // consumer, one sum per window
    dotProductUnit dotProduct (
        .clk         (clk),
        .rstN        (rstN),
        .kernelWrite (kernelWrite),
        .kernelIndex (kernelIndex),
        .kernelData  (kernelData),
        .blockData   (blockData),
        .blockValid  (blockValid),
        .resultValid (resultValid),
        .result      (result)
    );

endmodule

// ==== verification/accelChecker.sv ====
`include "accel_macros.svh"

module accelChecker (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          hostWrite,
    input  logic [`ACCEL_ADDR_WIDTH-1:0]  hostAddr,
    input  accelPkg::sampleT              hostData,
    input  logic                          kernelWrite,
    input  logic [`ACCEL_INDEX_WIDTH-1:0] kernelIndex,
    input  accelPkg::sampleT              kernelData,
    input  logic                          start,
    input  logic [`ACCEL_ADDR_WIDTH-1:0]  baseAddr,
    input  logic [`ACCEL_ADDR_WIDTH-1:0]  stride,
    input  logic [`ACCEL_COUNT_WIDTH-1:0] windowCount,
    input  logic                          busy,
    input  logic                          resultValid,
    input  accelPkg::accT                 result,
    output int                            valueErrors,
    output int                            protocolErrors,
    output int                            pendingCount
);

    timeunit 1ns;
    timeprecision 1ps;

    // mirrors of the sample memory and the kernel taps
    accelPkg::sampleT memModel [`ACCEL_MEM_DEPTH];
    accelPkg::sampleT kernelModel [`ACCEL_BLOCK_SIZE];

    // expected sums in order, with the cycle each one is due
    accelPkg::accT expSum [$];
    longint        expCycle [$];

    longint cycle = 0;
    // reads still to go in the modelled run
    int windowsLeft = 0;
    int valueCount = 0;
    int protocolCount = 0;
    int pendingNow = 0;

    assign valueErrors    = valueCount;
    assign protocolErrors = protocolCount;
    assign pendingCount   = pendingNow;

    // 25 taps against consecutive words, address wraps at 4096
    function automatic accelPkg::accT windowSum(input logic [`ACCEL_ADDR_WIDTH-1:0] first);
        longint acc;
        logic [`ACCEL_ADDR_WIDTH-1:0] wordAddr;
        acc = 0;
        for (int i = 0; i < `ACCEL_BLOCK_SIZE; i++) begin
            wordAddr = first + `ACCEL_ADDR_WIDTH'(i);
            acc += longint'(kernelModel[i]) * longint'(memModel[wordAddr]);
        end
        return accelPkg::accT'(acc);
    endfunction

    always @(posedge clk) begin
        logic [`ACCEL_ADDR_WIDTH-1:0] addr;
        int windows;
        if (!rstN) begin
            windowsLeft = 0;
            expSum.delete();
            expCycle.delete();
        end else begin
            cycle++;
            // busy only while the model has reads left
            if (busy !== (windowsLeft != 0)) begin
                protocolCount++;
                $display("FAILED busy: got %h, expected %h", busy, windowsLeft != 0);
            end
            if (resultValid === 1'b1) begin
                if (expSum.size() == 0) begin
                    protocolCount++;
                    $display("extra result %h at cycle %0d with nothing outstanding",
                             result, cycle);
                end else begin
                    if (expCycle[0] != cycle) begin
                        protocolCount++;
                        $display("result arrived at cycle %0d but was due at cycle %0d",
                                 cycle, expCycle[0]);
                    end
                    if (result !== expSum[0]) begin
                        valueCount++;
                        $display("FAILED result: got %h, expected %h", result, expSum[0]);
                    end
                    void'(expSum.pop_front());
                    void'(expCycle.pop_front());
                end
            end else if (resultValid !== 1'b0) begin
                protocolCount++;
                $display("resultValid is unknown at cycle %0d", cycle);
            end else if (expCycle.size() != 0 && expCycle[0] <= cycle) begin
                protocolCount++;
                $display("result due at cycle %0d never arrived", expCycle[0]);
                void'(expSum.pop_front());
                void'(expCycle.pop_front());
            end
            // host writes land only while idle
            if (hostWrite && windowsLeft == 0) begin
                memModel[hostAddr] = hostData;
            end
            if (kernelWrite && kernelIndex < `ACCEL_INDEX_WIDTH'(`ACCEL_BLOCK_SIZE)) begin
                kernelModel[kernelIndex] = kernelData;
            end
            if (windowsLeft != 0) begin
                windowsLeft--;
            end else if (start === 1'b1) begin
                // zero count still runs one window
                windows = (windowCount == '0) ? 1 : int'(windowCount);
                addr = baseAddr;
                for (int k = 0; k < windows; k++) begin
                    expSum.push_back(windowSum(addr));
                    // start edge, three pipeline registers, then one per window
                    expCycle.push_back(cycle + 4 + k);
                    addr = addr + stride;
                end
                windowsLeft = windows;
            end
        end
        pendingNow = expSum.size();
    end

endmodule

// ==== verification/accelTb.sv ====
`include "accel_macros.svh"

module accelTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RUN_COUNT = 40;
    // watchdog budget in cycles, worst case per phase
    // fill costs at most one idle cycle per word, plus four extra ranges
    localparam int FILL_CYCLES   = 2 * `ACCEL_MEM_DEPTH + 4 * 65;
    localparam int KERNEL_CYCLES = `ACCEL_BLOCK_SIZE + 1;
    // extra writes, tap reload, start, up to 8 windows, idle cycle, drain
    localparam int RUN_CYCLES    = 33 + 6 + 1 + 8 + 1 + 8;
    localparam int LIMIT_CYCLES  =
        2 * (5 + FILL_CYCLES + KERNEL_CYCLES + RUN_COUNT * RUN_CYCLES) + 200;

    logic                          clk = 1'b0;
    logic                          rstN;
    logic                          hostWrite;
    logic [`ACCEL_ADDR_WIDTH-1:0]  hostAddr;
    accelPkg::sampleT              hostData;
    logic                          kernelWrite;
    logic [`ACCEL_INDEX_WIDTH-1:0] kernelIndex;
    accelPkg::sampleT              kernelData;
    logic                          start;
    logic [`ACCEL_ADDR_WIDTH-1:0]  baseAddr;
    logic [`ACCEL_ADDR_WIDTH-1:0]  stride;
    logic [`ACCEL_COUNT_WIDTH-1:0] windowCount;
    logic                          busy;
    logic                          resultValid;
    accelPkg::accT                 result;
    int                            valueErrors;
    int                            protocolErrors;
    int                            pendingCount;
    integer                        seed;

    // 8 ns period
    always #4 clk = ~clk;

    accelTop uut (
        .clk         (clk),
        .rstN        (rstN),
        .hostWrite   (hostWrite),
        .hostAddr    (hostAddr),
        .hostData    (hostData),
        .kernelWrite (kernelWrite),
        .kernelIndex (kernelIndex),
        .kernelData  (kernelData),
        .start       (start),
        .baseAddr    (baseAddr),
        .stride      (stride),
        .windowCount (windowCount),
        .busy        (busy),
        .resultValid (resultValid),
        .result      (result)
    );

    accelChecker resultChecker (
        .clk            (clk),
        .rstN           (rstN),
        .hostWrite      (hostWrite),
        .hostAddr       (hostAddr),
        .hostData       (hostData),
        .kernelWrite    (kernelWrite),
        .kernelIndex    (kernelIndex),
        .kernelData     (kernelData),
        .start          (start),
        .baseAddr       (baseAddr),
        .stride         (stride),
        .windowCount    (windowCount),
        .busy           (busy),
        .resultValid    (resultValid),
        .result         (result),
        .valueErrors    (valueErrors),
        .protocolErrors (protocolErrors),
        .pendingCount   (pendingCount)
    );

    function automatic logic coinFlip();
        return 1'($random(seed));
    endfunction

    function automatic int randomBelow(input int limit);
        return int'({$random(seed)} % limit);
    endfunction

    // consecutive word writes, wrapping at the top
    task automatic writeWords(input logic [`ACCEL_ADDR_WIDTH-1:0] first, input int length);
        for (int i = 0; i < length; i++) begin
            @(posedge clk);
            hostWrite <= 1'b1;
            hostAddr  <= first + `ACCEL_ADDR_WIDTH'(i);
            hostData  <= `ACCEL_DATA_WIDTH'($random(seed));
        end
        @(posedge clk);
        hostWrite <= 1'b0;
    endtask

    // whole memory in ranges of random length, then a few random spots
    task automatic fillMemory();
        int addr;
        int length;
        addr = 0;
        while (addr < `ACCEL_MEM_DEPTH) begin
            length = 1 + randomBelow(64);
            if (addr + length > `ACCEL_MEM_DEPTH) begin
                length = `ACCEL_MEM_DEPTH - addr;
            end
            writeWords(`ACCEL_ADDR_WIDTH'(addr), length);
            addr += length;
        end
        repeat (4) writeWords(`ACCEL_ADDR_WIDTH'($random(seed)), 1 + randomBelow(64));
    endtask

    // taps in order, or random indices for a partial reload
    task automatic loadTaps(input int count, input logic shuffled);
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            kernelWrite <= 1'b1;
            kernelIndex <= `ACCEL_INDEX_WIDTH'(shuffled ? randomBelow(`ACCEL_BLOCK_SIZE) : i);
            kernelData  <= `ACCEL_DATA_WIDTH'($random(seed));
        end
        @(posedge clk);
        kernelWrite <= 1'b0;
    endtask

    // busy low, then the burst of results has come and gone
    task automatic waitDrain();
        do @(negedge clk); while (busy);
        while (!resultValid) @(negedge clk);
        while (resultValid) @(negedge clk);
    endtask

    task automatic launchRun(input int runIndex);
        logic [`ACCEL_ADDR_WIDTH-1:0]  base;
        logic [`ACCEL_ADDR_WIDTH-1:0]  step;
        logic [`ACCEL_COUNT_WIDTH-1:0] count;
        int windows;
        // every fourth run near the top so blocks wrap
        if (runIndex % 4 == 0) begin
            base = `ACCEL_ADDR_WIDTH'(4070 + randomBelow(20));
        end else begin
            base = `ACCEL_ADDR_WIDTH'($random(seed));
        end
        // small strides give overlapping windows
        if (runIndex % 3 == 0) begin
            step = `ACCEL_ADDR_WIDTH'(randomBelow(8));
        end else begin
            step = `ACCEL_ADDR_WIDTH'($random(seed));
        end
        count = `ACCEL_COUNT_WIDTH'(randomBelow(9));
        windows = (count == '0) ? 1 : int'(count);
        @(posedge clk);
        start       <= 1'b1;
        baseAddr    <= base;
        stride      <= step;
        windowCount <= count;
        // write in the start cycle is taken and lands inside the first window
        hostWrite   <= coinFlip();
        hostAddr    <= base + `ACCEL_ADDR_WIDTH'(randomBelow(`ACCEL_BLOCK_SIZE));
        hostData    <= `ACCEL_DATA_WIDTH'($random(seed));
        // junk while busy, every bit of it must be dropped
        repeat (windows) begin
            @(posedge clk);
            start       <= coinFlip();
            hostWrite   <= coinFlip();
            hostAddr    <= base + `ACCEL_ADDR_WIDTH'(randomBelow(`ACCEL_BLOCK_SIZE));
            hostData    <= `ACCEL_DATA_WIDTH'($random(seed));
            baseAddr    <= `ACCEL_ADDR_WIDTH'($random(seed));
            stride      <= `ACCEL_ADDR_WIDTH'($random(seed));
            windowCount <= `ACCEL_COUNT_WIDTH'($random(seed));
        end
        @(posedge clk);
        start     <= 1'b0;
        hostWrite <= 1'b0;
        waitDrain();
    endtask

    initial begin
        seed        = 32'h78c5_cdc6;
        rstN        = 1'b0;
        hostWrite   = 1'b0;
        hostAddr    = '0;
        hostData    = '0;
        kernelWrite = 1'b0;
        kernelIndex = '0;
        kernelData  = '0;
        start       = 1'b0;
        baseAddr    = '0;
        stride      = '0;
        windowCount = '0;
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        // quiet cycles, busy and resultValid stay low
        repeat (3) @(posedge clk);
        fillMemory();
        loadTaps(`ACCEL_BLOCK_SIZE, 1'b0);
        for (int r = 0; r < RUN_COUNT; r++) begin
            if (coinFlip()) begin
                writeWords(`ACCEL_ADDR_WIDTH'($random(seed)), 1 + randomBelow(32));
            end
            if (r % 5 == 4) begin
                loadTaps(1 + randomBelow(5), 1'b1);
            end
            launchRun(r);
        end
        repeat (2) @(posedge clk);
        $display("errors: %0d value, %0d protocol, %0d results outstanding",
                 valueErrors, protocolErrors, pendingCount);
        if (valueErrors == 0 && protocolErrors == 0 && pendingCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("watchdog timeout: the test did not finish within %0d cycles", LIMIT_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+logic
logic/accelPkg.sv
logic/windowSequencer.sv
logic/blockMemory.sv
logic/dotProductUnit.sv
logic/accelTop.sv
verification/accelChecker.sv
verification/accelTb.sv

// ==== Bender.yml ====
package:
  name: accel

sources:
  # design, package first
  - include_dirs:
      - logic
    files:
      - logic/accelPkg.sv
      - logic/windowSequencer.sv
      - logic/blockMemory.sv
      - logic/dotProductUnit.sv
      - logic/accelTop.sv

  # testbench, top module accelTb
  - target: test
    include_dirs:
      - logic
    files:
      - verification/accelChecker.sv
      - verification/accelTb.sv
